/* logic/wu_pkg.sv */
package wu_pkg;

	localparam int DATA_W       = 32;	// FP32 word
	localparam int EXP_W        = 8;	// Biased exponent field
	localparam int MANT_W       = 24;	// Mantissa incl. hidden bit
	localparam int WEIGHT_COUNT = 16;	// Weights in the bank
	localparam int INDEX_W      = 4;	// Bank address width
	localparam int PIPE_DEPTH   = 5;	// Accept to write-back, minus one

	typedef struct packed {
		logic [INDEX_W-1:0] index;	// Weight to update
		logic [DATA_W-1:0]  error;	// Already scaled by learning rate
	} wu_req_t;

	typedef struct packed {
		logic               valid;
		logic [INDEX_W-1:0] index;
		logic [DATA_W-1:0]  weight;	// Current weight
		logic [DATA_W-1:0]  neg_error;	// Error, sign flipped
	} fp_op_t;

	typedef struct packed {
		logic               valid;
		logic [INDEX_W-1:0] index;
		logic               sign;	// Sign of larger operand
		logic [EXP_W-1:0]   exp;	// Larger exponent
		logic [MANT_W-1:0]  mant_a;	// Larger mantissa
		logic [MANT_W-1:0]  mant_b;	// Smaller, aligned
		logic               sub;	// Signs differ
	} align_t;

	typedef struct packed {
		logic               valid;
		logic [INDEX_W-1:0] index;
		logic               sign;
		logic [EXP_W-1:0]   exp;
		logic [MANT_W:0]    mant;	// Raw sum, MSB is carry
	} sum_t;

	typedef struct packed {
		logic                    valid;
		logic [INDEX_W-1:0]      index;
		logic                    sign;
		logic signed [EXP_W+1:0] exp;	// Can go to zero or below
		logic [MANT_W-1:0]       mant;	// Normalized
	} norm_t;

	typedef struct packed {
		logic               valid;
		logic [INDEX_W-1:0] index;
		logic [DATA_W-1:0]  weight;	// New weight
	} wu_result_t;

endpackage

/* logic/weight_bank.sv */
`timescale 1ns/1ps
module weight_bank (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_valid,
	input  wu_pkg::wu_req_t              i_req,
	output logic                         o_ready,
	input  logic                         i_load,
	input  logic [wu_pkg::INDEX_W-1:0]   i_load_index,
	input  logic [wu_pkg::DATA_W-1:0]    i_load_weight,
	input  wu_pkg::wu_result_t           i_wb,
	output wu_pkg::fp_op_t               o_op
);
	import wu_pkg::*;

	logic [DATA_W-1:0]   weights [WEIGHT_COUNT];	// The bank
	logic [PIPE_DEPTH-1:0] busy_v;	// In-flight slot valid
	logic [INDEX_W-1:0]  busy_idx [PIPE_DEPTH];	// In-flight slot index
	logic                hazard;	// Requested index still in flight
	logic                accept;

	// Match against every update not yet written back
	always_comb begin
		hazard = 1'b0;
		for (int i = 0; i < PIPE_DEPTH; i++) begin
			if (busy_v[i] && (busy_idx[i] == i_req.index))
				hazard = 1'b1;
		end
	end

	assign o_ready = !i_load && !hazard;	// Loads block updates too
	assign accept  = i_valid && o_ready;

	// Hazard tracker shift register
	always_ff @(posedge clk) begin
		busy_idx[0] <= i_req.index;
		for (int i = 1; i < PIPE_DEPTH; i++)
			busy_idx[i] <= busy_idx[i-1];
		if (i_reset)
			busy_v <= '0;
		else
			busy_v <= {busy_v[PIPE_DEPTH-2:0], accept};	// Oldest drops out at write-back
	end

	// Operand register into the adder
	always_ff @(posedge clk) begin
		o_op.index     <= i_req.index;
		o_op.weight    <= weights[i_req.index];	// Read before any write this edge
		o_op.neg_error <= {~i_req.error[DATA_W-1], i_req.error[DATA_W-2:0]};	// w - e = w + (-e)
		if (i_reset)
			o_op.valid <= 1'b0;
		else
			o_op.valid <= accept;
	end

	// Weight storage, write-back and direct load
	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < WEIGHT_COUNT; i++)
				weights[i] <= '0;	// All weights start at +0
		end else begin
			if (i_wb.valid)
				weights[i_wb.index] <= i_wb.weight;	// Result from normalizer
			if (i_load)
				weights[i_load_index] <= i_load_weight;	// Only when idle
		end
	end

endmodule

/* logic/fp_add_align.sv */
`timescale 1ns/1ps
module fp_add_align (
	input  logic            clk,
	input  logic            i_reset,
	input  wu_pkg::fp_op_t  i_op,
	output wu_pkg::align_t  o_align
);
	import wu_pkg::*;

	logic               w_sign, e_sign;
	logic [EXP_W-1:0]   w_exp, e_exp;
	logic [MANT_W-1:0]  w_mant, e_mant;
	logic               w_big;	// Weight has larger magnitude
	logic [EXP_W-1:0]   big_exp, small_exp;
	logic [EXP_W-1:0]   shift;	// Exponent difference
	logic [MANT_W-1:0]  small_mant;
	align_t             align_c;

	always_comb begin
		// Unpack, exponent 0 counts as zero
		w_sign = i_op.weight[DATA_W-1];
		w_exp  = i_op.weight[DATA_W-2 -: EXP_W];
		w_mant = (w_exp == '0) ? '0 : {1'b1, i_op.weight[MANT_W-2:0]};
		e_sign = i_op.neg_error[DATA_W-1];
		e_exp  = i_op.neg_error[DATA_W-2 -: EXP_W];
		e_mant = (e_exp == '0) ? '0 : {1'b1, i_op.neg_error[MANT_W-2:0]};

		// Magnitude compare on exponent then mantissa
		w_big = {w_exp, w_mant} >= {e_exp, e_mant};

		big_exp    = w_big ? w_exp  : e_exp;
		small_exp  = w_big ? e_exp  : w_exp;
		small_mant = w_big ? e_mant : w_mant;
		shift      = big_exp - small_exp;	// Never negative

		align_c.valid  = i_op.valid;
		align_c.index  = i_op.index;
		align_c.sign   = w_big ? w_sign : e_sign;	// Result follows larger operand
		align_c.exp    = big_exp;
		align_c.mant_a = w_big ? w_mant : e_mant;
		align_c.mant_b = (shift >= MANT_W) ? '0 : (small_mant >> shift);	// Truncating
		align_c.sub    = w_sign ^ e_sign;
	end

	always_ff @(posedge clk) begin
		o_align <= align_c;
		if (i_reset)
			o_align.valid <= 1'b0;	// Payload keeps its value
	end

endmodule

/* logic/fp_add_sum.sv */
`timescale 1ns/1ps
module fp_add_sum (
	input  logic            clk,
	input  logic            i_reset,
	input  wu_pkg::align_t  i_align,
	output wu_pkg::sum_t    o_sum
);
	import wu_pkg::*;

	logic [MANT_W:0] mant_a;	// Zero-extended for carry
	logic [MANT_W:0] mant_b;
	sum_t            sum_c;

	assign mant_a = {1'b0, i_align.mant_a};
	assign mant_b = {1'b0, i_align.mant_b};

	always_comb begin
		sum_c.valid = i_align.valid;
		sum_c.index = i_align.index;
		sum_c.sign  = i_align.sign;
		sum_c.exp   = i_align.exp;
		// Larger minus smaller, so no borrow out
		sum_c.mant  = i_align.sub ? (mant_a - mant_b) : (mant_a + mant_b);
	end

	always_ff @(posedge clk) begin
		o_sum <= sum_c;
		if (i_reset)
			o_sum.valid <= 1'b0;
	end

endmodule

/* logic/fp_add_norm.sv */
`timescale 1ns/1ps
module fp_add_norm (
	input  logic               clk,
	input  logic               i_reset,
	input  wu_pkg::sum_t       i_sum,
	output wu_pkg::wu_result_t o_result
);
	import wu_pkg::*;

	logic [4:0]          lz;	// Leading zeros, 0..24
	norm_t               norm_c;
	norm_t               norm_q;	// Between the two stages
	wu_result_t          result_c;
	logic                flush;	// Underflow or exact zero

	// Count leading zeros of the mantissa without carry bit
	function automatic logic [4:0] count_lz(input logic [MANT_W-1:0] m);
		logic [4:0] n;
		logic       found;
		n = 5'd0;
		found = 1'b0;
		for (int i = MANT_W-1; i >= 0; i--) begin
			if (!found && !m[i])
				n = n + 5'd1;
			else
				found = 1'b1;
		end
		return n;
	endfunction

	assign lz = count_lz(i_sum.mant[MANT_W-1:0]);

	// Stage one: carry shift right or leading-zero shift left
	always_comb begin
		norm_c.valid = i_sum.valid;
		norm_c.index = i_sum.index;
		norm_c.sign  = i_sum.sign;
		if (i_sum.mant[MANT_W]) begin
			norm_c.mant = i_sum.mant[MANT_W:1];	// Low bit dropped
			norm_c.exp  = $signed({2'b00, i_sum.exp}) + 10'sd1;
		end else begin
			norm_c.mant = i_sum.mant[MANT_W-1:0] << lz;
			norm_c.exp  = $signed({2'b00, i_sum.exp}) - $signed({5'b00000, lz});
		end
	end

	always_ff @(posedge clk) begin
		norm_q <= norm_c;
		if (i_reset)
			norm_q.valid <= 1'b0;
	end

	// Stage two: flush then repack
	assign flush = (norm_q.mant == '0) || (norm_q.exp <= 0);

	always_comb begin
		result_c.valid = norm_q.valid;
		result_c.index = norm_q.index;
		if (flush)
			result_c.weight = '0;	// Always +0, sign dropped
		else
			result_c.weight = {norm_q.sign, norm_q.exp[EXP_W-1:0], norm_q.mant[MANT_W-2:0]};
	end

	always_ff @(posedge clk) begin
		o_result <= result_c;
		if (i_reset)
			o_result.valid <= 1'b0;	// Single-cycle strobe per result
	end

endmodule

/* logic/update_weight.sv */
`timescale 1ns/1ps
module update_weight (
	input  logic                       clk,
	input  logic                       i_reset,
	input  logic                       i_valid,
	input  wu_pkg::wu_req_t            i_req,
	output logic                       o_ready,
	input  logic                       i_load,
	input  logic [wu_pkg::INDEX_W-1:0] i_load_index,
	input  logic [wu_pkg::DATA_W-1:0]  i_load_weight,
	output wu_pkg::wu_result_t         o_result
);
	import wu_pkg::*;

	fp_op_t  op;	// Bank to align
	align_t  align;	// Align to sum
	sum_t    sum;	// Sum to normalizer

	weight_bank u_bank (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_req         (i_req),
		.o_ready       (o_ready),
		.i_load        (i_load),
		.i_load_index  (i_load_index),
		.i_load_weight (i_load_weight),
		.i_wb          (o_result),	// Write-back one edge after output
		.o_op          (op)
	);

	fp_add_align u_align (
		.clk     (clk),
		.i_reset (i_reset),
		.i_op    (op),
		.o_align (align)
	);

	fp_add_sum u_sum (
		.clk     (clk),
		.i_reset (i_reset),
		.i_align (align),
		.o_sum   (sum)
	);

	fp_add_norm u_norm (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_sum    (sum),
		.o_result (o_result)
	);

endmodule

/* bench/update_weight_asserts.sv */
`timescale 1ns/1ps
module update_weight_asserts (
	input logic               clk,
	input logic               i_reset,
	input logic               i_valid,
	input logic               o_ready,
	input logic               i_load,
	input wu_pkg::fp_op_t     i_op,
	input wu_pkg::wu_result_t o_result
);
	import wu_pkg::*;

	logic [PIPE_DEPTH-1:0] inflight;	// Accepts not yet written back
	int                    fails = 0;

	always_ff @(posedge clk) begin
		if (i_reset)
			inflight <= '0;
		else
			inflight <= {inflight[PIPE_DEPTH-2:0], i_valid && o_ready};
	end

	assert property (@(posedge clk) $past(i_reset) |-> !o_result.valid)
		else begin
			fails++;
			$error("o_result.valid high during reset");
		end

	// Bank must not register an operand for a request offered during a load
	assert property (@(posedge clk) disable iff (i_reset) i_load |=> !i_op.valid)
		else begin
			fails++;
			$error("update accepted while a load is active");
		end

	// Load would collide with a pending write-back
	assert property (@(posedge clk) disable iff (i_reset) i_load |-> inflight == '0)
		else begin
			fails++;
			$error("load issued while an update is in flight");
		end

endmodule

bind update_weight update_weight_asserts u_asserts (.*, .i_op(op));

/* bench/tb_update_weight.sv */
`timescale 1ns/1ps
module tb_update_weight;
	import wu_pkg::*;

	localparam int N_REQ       = 276;	// 16+16+200+12+16+16 updates
	localparam int CYCLE_LIMIT = N_REQ * 8 + 200;

	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [DATA_W-1:0]  weight;
		logic [31:0]        cyc;	// Accept edge
	} expect_t;

	logic               clk = 1'b0;
	logic               i_reset;
	logic               i_valid;
	wu_req_t            i_req;
	logic               o_ready;
	logic               i_load;
	logic [INDEX_W-1:0] i_load_index;
	logic [DATA_W-1:0]  i_load_weight;
	wu_result_t         o_result;

	integer             seed = 32'he44d_f720;
	logic [DATA_W-1:0]  model_w [WEIGHT_COUNT];	// Reference copy of the bank
	expect_t            exp_q [$];	// Results still to come, in order
	int                 cycle = 0;
	int                 errors = 0;
	int                 checks = 0;
	int                 tests = 0;
	int                 test_err;
	int                 last_accept;
	int                 prev;
	logic [INDEX_W-1:0] idx;
	logic [DATA_W-1:0]  err;
	string              test_name = "";

	update_weight dut (.*);

	always #4 clk = ~clk;	// 8 ns period

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// w - e with truncation, exponent 0 counts as zero
	function automatic logic [DATA_W-1:0] model_sub(input logic [DATA_W-1:0] w,
			input logic [DATA_W-1:0] e);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [24:0]       ma;
		logic [24:0]       mb;
		logic [24:0]       m;
		int                ex;
		int                d;
		a  = w;
		b  = e ^ 32'h8000_0000;	// Add the negated error
		ma = (a[30:23] == 0) ? '0 : {2'b01, a[22:0]};
		mb = (b[30:23] == 0) ? '0 : {2'b01, b[22:0]};
		if ({b[30:23], mb} > {a[30:23], ma}) begin	// a holds the larger magnitude
			{a, b}   = {b, a};
			{ma, mb} = {mb, ma};
		end
		d  = a[30:23] - b[30:23];
		mb = (d > 23) ? '0 : (mb >> d);	// Bits shifted out are lost
		m  = (a[31] != b[31]) ? (ma - mb) : (ma + mb);
		ex = a[30:23];
		if (m[24]) begin
			m  = m >> 1;
			ex = ex + 1;
		end
		while (m != 0 && !m[23]) begin
			m  = m << 1;
			ex = ex - 1;
		end
		if (m == 0 || ex <= 0)
			return '0;	// Flush to +0
		return {a[31], ex[7:0], m[22:0]};
	endfunction

	// Exponent 100..140, random sign and fraction
	function automatic logic [DATA_W-1:0] random_fp();
		logic [DATA_W-1:0] r;
		logic [7:0]        ex;
		r  = $random(seed);
		ex = 8'd100 + 8'($unsigned($random(seed)) % 41);
		return {r[31], ex, r[22:0]};
	endfunction

	// A request offered alongside the load must be refused
	task automatic load(input logic [INDEX_W-1:0] index, input logic [DATA_W-1:0] value);
		i_load         = 1'b1;
		i_load_index   = index;
		i_load_weight  = value;
		i_valid        = 1'b1;
		i_req.index    = index;
		model_w[index] = value;
		@(negedge clk);
		i_load  = 1'b0;
		i_valid = 1'b0;
	endtask

	// Hold the request until the bank takes it
	task automatic issue(input logic [INDEX_W-1:0] index, input logic [DATA_W-1:0] err_in);
		i_valid     = 1'b1;
		i_req.index = index;
		i_req.error = err_in;
		#1;
		while (o_ready !== 1'b1) begin	// Stalled by hazard
			@(negedge clk);
			#1;
		end
		last_accept    = cycle + 1;	// Taken at the coming edge
		model_w[index] = model_sub(model_w[index], err_in);
		exp_q.push_back(expect_t'{index, model_w[index], 32'(last_accept)});
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	// Drain, report the finished test, start the next
	task automatic next_test(input string name);
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);	// Last write-back lands
		if (test_name != "") begin
			tests++;
			$display("test %s done, %0d errors", test_name, errors - test_err);
		end
		test_name = name;
		test_err  = errors;
	endtask

	// Every result checked against the queue head, latency included
	always @(negedge clk) begin
		expect_t e;
		if (o_result.valid === 1'b1) begin
			checks++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: a result came out with no update pending", test_name);
			end else begin
				e = exp_q.pop_front();
				if (o_result.index !== e.index || o_result.weight !== e.weight
						|| cycle != e.cyc + 4) begin
					errors++;
					$display("MISMATCH %s: expected %0d:%h at edge %0d, actual %0d:%h at edge %0d",
						test_name, e.index, e.weight, e.cyc + 4, o_result.index,
						o_result.weight, cycle);
				end
			end
		end
	end

	initial begin
		i_reset       = 1'b1;
		i_valid       = 1'b0;
		i_req         = '0;
		i_load        = 1'b0;
		i_load_index  = '0;
		i_load_weight = '0;
		for (int i = 0; i < WEIGHT_COUNT; i++)
			model_w[i] = '0;
		repeat (10) @(negedge clk);
		i_reset = 1'b0;

		next_test("reset_state");
		repeat (4) begin
			@(negedge clk);
			checks++;
			if (o_result.valid !== 1'b0 || o_ready !== 1'b1) begin
				errors++;
				$display("MISMATCH reset_state: expected valid 0 ready 1, actual valid %b ready %b",
					o_result.valid, o_ready);
			end
		end
		for (int i = 0; i < WEIGHT_COUNT; i++)
			issue(INDEX_W'(i), random_fp());	// Zero weight gives negated error

		next_test("load_update");
		for (int i = 0; i < WEIGHT_COUNT; i++)
			load(INDEX_W'(i), random_fp());
		for (int i = 0; i < WEIGHT_COUNT; i++)
			issue(INDEX_W'(i), random_fp());

		next_test("streaming");
		repeat (200) begin
			if (($random(seed) & 7) == 0)
				@(negedge clk);	// Idle about one cycle in eight
			issue(INDEX_W'($random(seed)), random_fp());
		end

		next_test("hazard");
		repeat (4) begin
			idx = INDEX_W'($random(seed));
			issue(idx, random_fp());
			repeat (2) begin
				prev = last_accept;
				issue(idx, random_fp());
				checks++;
				if (last_accept - prev != 6) begin
					errors++;
					$display("MISMATCH hazard: accept gap expected 6 actual %0d",
						last_accept - prev);
				end
			end
		end

		next_test("cancel");
		for (int i = 0; i < WEIGHT_COUNT; i++) begin
			err = model_w[i];	// Exact cancellation
			if (i < 8)
				err[7:0] = err[7:0] ^ 8'(($unsigned($random(seed)) % 255) + 1);	// Near
			issue(INDEX_W'(i), err);
		end

		next_test("write_back");
		for (int i = 0; i < WEIGHT_COUNT; i++)
			issue(INDEX_W'(i), '0);	// Returns stored weight
		next_test("");

		if (dut.u_asserts.fails != 0) begin
			errors = errors + dut.u_asserts.fails;
			$display("%0d assertion failures in the bound checker", dut.u_asserts.fails);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* files.f */
logic/wu_pkg.sv
logic/weight_bank.sv
logic/fp_add_align.sv
logic/fp_add_sum.sv
logic/fp_add_norm.sv
logic/update_weight.sv
bench/update_weight_asserts.sv
bench/tb_update_weight.sv

/* Bender.yml */
package:
  name: update_weight

sources:
  - logic/wu_pkg.sv
  - logic/weight_bank.sv
  - logic/fp_add_align.sv
  - logic/fp_add_sum.sv
  - logic/fp_add_norm.sv
  - logic/update_weight.sv
  - target: test
    files:
      - bench/update_weight_asserts.sv
      - bench/tb_update_weight.sv
